//--- rtl/spwm_pkg.sv
package spwm_pkg;

    localparam int table_len = 30;
    localparam int duty_w = 8;
    localparam int freq_w = 32;

    typedef enum logic [0:0] {
        op_set_freq = 1'b0,
        op_stop     = 1'b1
    } spwm_op_e;

    // one sine period in 30 steps, offset to mid-scale.
    function automatic logic [duty_w-1:0] sine_sample(input logic [$clog2(table_len)-1:0] index);
        logic [duty_w-1:0] value;
        case (index)
            5'd0: value = 8'd128;
            5'd1: value = 8'd153;
            5'd2: value = 8'd177;
            5'd3: value = 8'd199;
            5'd4: value = 8'd217;
            5'd5: value = 8'd232;
            5'd6: value = 8'd242;
            5'd7: value = 8'd247;
            5'd8: value = 8'd247;
            5'd9: value = 8'd242;
            5'd10: value = 8'd232;
            5'd11: value = 8'd217;
            5'd12: value = 8'd199;
            5'd13: value = 8'd177;
            5'd14: value = 8'd153;
            5'd15: value = 8'd128;
            5'd16: value = 8'd103;
            5'd17: value = 8'd79;
            5'd18: value = 8'd57;
            5'd19: value = 8'd39;
            5'd20: value = 8'd24;
            5'd21: value = 8'd14;
            5'd22: value = 8'd9;
            5'd23: value = 8'd9;
            5'd24: value = 8'd14;
            5'd25: value = 8'd24;
            5'd26: value = 8'd39;
            5'd27: value = 8'd57;
            5'd28: value = 8'd79;
            5'd29: value = 8'd103;
            default: value = 8'd128;
        endcase
        return value;
    endfunction

endpackage

//--- rtl/spwm_cmd_port.sv
module spwm_cmd_port (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                cmd_req,
    input  spwm_pkg::spwm_op_e                  cmd_op,
    input  logic signed [spwm_pkg::freq_w-1:0]  cmd_freq,
    output logic                                cmd_ack,
    output logic signed [spwm_pkg::freq_w-1:0]  freq
);

    logic                               new_cmd;
    logic signed [spwm_pkg::freq_w-1:0] next_freq;

    // a request is new only while the previous one is fully retired.
    assign new_cmd = cmd_req && !cmd_ack;

    always_comb begin
        case (cmd_op)
            spwm_pkg::op_set_freq: next_freq = cmd_freq;
            spwm_pkg::op_stop: next_freq = '0;
            default: next_freq = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_ack <= 1'b0;
            freq <= '0;
        end else begin
            if (new_cmd) begin
                // command lands together with the ack edge.
                cmd_ack <= 1'b1;
                freq <= next_freq;
            end else if (cmd_ack && !cmd_req) begin
                cmd_ack <= 1'b0;
            end
        end
    end

    // host must keep req up until it has seen the ack.
    property p_req_held;
        @(posedge clk) disable iff (rst)
        (cmd_req && !cmd_ack) |=> cmd_req;
    endproperty

    a_req_held: assert property (p_req_held)
        else $error("cmd_req dropped before cmd_ack was raised");

    property p_ack_reset;
        @(posedge clk) rst |=> !cmd_ack;
    endproperty

    a_ack_reset: assert property (p_ack_reset)
        else $error("cmd_ack not low after reset");

endmodule

//--- rtl/sine_phase_stepper.sv
module sine_phase_stepper #(
    parameter int start_index = 0
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic signed [spwm_pkg::freq_w-1:0] freq,
    output logic [spwm_pkg::duty_w-1:0]        duty
);

    localparam int index_w = $clog2(spwm_pkg::table_len);
    localparam logic [index_w-1:0] last_index = index_w'(spwm_pkg::table_len - 1);

    logic [spwm_pkg::freq_w-1:0]        mag;
    logic [spwm_pkg::freq_w-1:0]        div_cnt;
    logic signed [spwm_pkg::freq_w-1:0] freq_prev;
    logic [index_w-1:0]                 index;
    logic                               freq_changed;
    logic                               step;
    logic                               reverse;

    // magnitude sets the step period, sign the direction.
    assign reverse = freq[spwm_pkg::freq_w-1];
    assign mag = reverse ? (~freq + 1'b1) : freq;

    assign freq_changed = (freq != freq_prev);
    assign step = !freq_changed && (mag != '0) && (div_cnt == mag);

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            freq_prev <= '0;
        end else begin
            freq_prev <= freq;
            if (freq_changed || mag == '0 || step) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // table index wraps at both ends.
    always_ff @(posedge clk) begin
        if (rst) begin
            index <= index_w'(start_index);
        end else if (step) begin
            if (reverse) begin
                if (index == '0) begin
                    index <= last_index;
                end else begin
                    index <= index - 1'b1;
                end
            end else begin
                if (index == last_index) begin
                    index <= '0;
                end else begin
                    index <= index + 1'b1;
                end
            end
        end
    end

    // stopped phase outputs no pulse at all.
    assign duty = (mag == '0) ? '0 : spwm_pkg::sine_sample(index);

    property p_index_range;
        @(posedge clk) disable iff (rst)
        index < index_w'(spwm_pkg::table_len);
    endproperty

    a_index_range: assert property (p_index_range)
        else $error("table index out of range: %0d", index);

endmodule

//--- rtl/pwm_carrier.sv
module pwm_carrier #(
    parameter int pwm_period = 255
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [spwm_pkg::duty_w-1:0] duty,
    output logic                        pwm
);

    localparam int cnt_w = (pwm_period > 1) ? $clog2(pwm_period) : 1;
    localparam int cmp_w = (cnt_w > spwm_pkg::duty_w) ? cnt_w : spwm_pkg::duty_w;
    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(pwm_period - 1);

    logic [cnt_w-1:0]            cnt;
    logic [cnt_w-1:0]            cnt_next;
    logic [spwm_pkg::duty_w-1:0] duty_q;
    logic [spwm_pkg::duty_w-1:0] duty_next;
    logic                        wrap;

    assign wrap = (cnt == last_cnt);
    assign cnt_next = wrap ? '0 : cnt + 1'b1;

    // new duty only at the period boundary.
    assign duty_next = wrap ? duty : duty_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
            duty_q <= '0;
            pwm <= 1'b0;
        end else begin
            cnt <= cnt_next;
            duty_q <= duty_next;
            // pulse is registered, so compare against next count.
            pwm <= (cmp_w'(cnt_next) < cmp_w'(duty_next));
        end
    end

    property p_zero_duty_low;
        @(posedge clk) disable iff (rst)
        (duty_q == '0) |-> !pwm;
    endproperty

    a_zero_duty_low: assert property (p_zero_duty_low)
        else $error("pwm high with zero latched duty");

endmodule

//--- rtl/spwm_top.sv
module spwm_top #(
    parameter int pwm_period = 255
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               cmd_req,
    input  spwm_pkg::spwm_op_e                 cmd_op,
    input  logic signed [spwm_pkg::freq_w-1:0] cmd_freq,
    output logic                               cmd_ack,
    output logic                               pwm_a,
    output logic                               pwm_b,
    output logic                               pwm_c
);

    logic signed [spwm_pkg::freq_w-1:0] freq;
    logic [spwm_pkg::duty_w-1:0]        duty_a;
    logic [spwm_pkg::duty_w-1:0]        duty_b;
    logic [spwm_pkg::duty_w-1:0]        duty_c;

    spwm_cmd_port u_cmd_port (
        .clk      (clk),
        .rst      (rst),
        .cmd_req  (cmd_req),
        .cmd_op   (cmd_op),
        .cmd_freq (cmd_freq),
        .cmd_ack  (cmd_ack),
        .freq     (freq)
    );

    // phases a third of the table apart.
    sine_phase_stepper #(.start_index(0)) u_step_a (
        .clk  (clk),
        .rst  (rst),
        .freq (freq),
        .duty (duty_a)
    );

    sine_phase_stepper #(.start_index(10)) u_step_b (
        .clk  (clk),
        .rst  (rst),
        .freq (freq),
        .duty (duty_b)
    );

    sine_phase_stepper #(.start_index(20)) u_step_c (
        .clk  (clk),
        .rst  (rst),
        .freq (freq),
        .duty (duty_c)
    );

    pwm_carrier #(.pwm_period(pwm_period)) u_pwm_a (
        .clk  (clk),
        .rst  (rst),
        .duty (duty_a),
        .pwm  (pwm_a)
    );

    pwm_carrier #(.pwm_period(pwm_period)) u_pwm_b (
        .clk  (clk),
        .rst  (rst),
        .duty (duty_b),
        .pwm  (pwm_b)
    );

    pwm_carrier #(.pwm_period(pwm_period)) u_pwm_c (
        .clk  (clk),
        .rst  (rst),
        .duty (duty_c),
        .pwm  (pwm_c)
    );

endmodule

//--- verification/spwm_tb.sv
module spwm_tb;

    localparam int pwm_period = 255;
    // 30 table steps x 4 periods per step x 3 frequency tests, plus margin.
    localparam int timeout_cycles = 300000;

    logic                               clk = 1'b0;
    logic                               rst;
    logic                               cmd_req;
    spwm_pkg::spwm_op_e                 cmd_op;
    logic signed [spwm_pkg::freq_w-1:0] cmd_freq;
    logic                               cmd_ack;
    logic                               pwm_a;
    logic                               pwm_b;
    logic                               pwm_c;

    int          cycle_cnt = 0;
    int          mon_cnt = 0;
    int          high_a = 0;
    int          high_b = 0;
    int          high_c = 0;
    int          rec_a[$];
    int          rec_b[$];
    int          rec_c[$];
    logic        prev_ack = 1'b0;
    logic        prev_req = 1'b0;
    int unsigned rng_state;
    int          last_idx;
    string       test_name;

    spwm_top #(.pwm_period(pwm_period)) u_dut (
        .clk      (clk),
        .rst      (rst),
        .cmd_req  (cmd_req),
        .cmd_op   (cmd_op),
        .cmd_freq (cmd_freq),
        .cmd_ack  (cmd_ack),
        .pwm_a    (pwm_a),
        .pwm_b    (pwm_b),
        .pwm_c    (pwm_c)
    );

    always #50 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            report_failure("timeout: the run did not finish within the cycle limit");
        end
    end

    // sine reference, one full turn in 30 entries.
    function automatic int table_ref(input int i);
        int t[spwm_pkg::table_len];
        t = '{128, 153, 177, 199, 217, 232, 242, 247, 247, 242,
              232, 217, 199, 177, 153, 128, 103, 79, 57, 39,
              24, 14, 9, 9, 14, 24, 39, 57, 79, 103};
        return t[i % spwm_pkg::table_len];
    endfunction

    function automatic int match_index(input int a, input int b, input int c);
        int found;
        found = -1;
        for (int i = 0; i < spwm_pkg::table_len; i++) begin
            if (a == table_ref(i) && b == table_ref(i + 10) && c == table_ref(i + 20)) begin
                found = i;
            end
        end
        return found;
    endfunction

    function automatic int unsigned xorshift(input int unsigned x);
        int unsigned y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // keeps the index moving at most one entry per carrier period.
    task automatic next_magnitude(output int mag);
        rng_state = xorshift(rng_state);
        mag = 2 * pwm_period + int'(rng_state % (2 * pwm_period + 1));
    endtask

    // high cycles per carrier period, counter aligned with reset release.
    always @(negedge clk) begin
        if (rst) begin
            // dut count is already one at the first sample.
            mon_cnt = 1;
            high_a = 0;
            high_b = 0;
            high_c = 0;
        end else begin
            high_a = high_a + (pwm_a ? 1 : 0);
            high_b = high_b + (pwm_b ? 1 : 0);
            high_c = high_c + (pwm_c ? 1 : 0);
            if (mon_cnt == pwm_period - 1) begin
                rec_a.push_back(high_a);
                rec_b.push_back(high_b);
                rec_c.push_back(high_c);
                high_a = 0;
                high_b = 0;
                high_c = 0;
                mon_cnt = 0;
            end else begin
                mon_cnt = mon_cnt + 1;
            end
        end
    end

    // ack may only rise under a held request and fall after the request dropped.
    always @(negedge clk) begin
        if (!rst) begin
            if (cmd_ack && !prev_ack) begin
                assert (cmd_req && prev_req)
                    else report_failure("handshake: cmd_ack rose without cmd_req held high");
            end
            if (!cmd_ack && prev_ack) begin
                assert (!prev_req)
                    else report_failure("handshake: cmd_ack fell while cmd_req was still high");
            end
        end
        prev_ack = cmd_ack;
        prev_req = cmd_req;
    end

    // -1 means all three phases had no pulse in that period.
    task automatic take_record(output int idx);
        int a;
        int b;
        int c;
        while (rec_a.size() == 0) begin
            @(negedge clk);
        end
        a = rec_a.pop_front();
        b = rec_b.pop_front();
        c = rec_c.pop_front();
        if (a == 0 && b == 0 && c == 0) begin
            idx = -1;
        end else begin
            idx = match_index(a, b, c);
            assert (idx >= 0) else report_failure($sformatf(
                "error %s: expected a table triple, actual a=%0d b=%0d c=%0d",
                test_name, a, b, c));
            last_idx = idx;
        end
    endtask

    // the first record after a command may straddle the command.
    task automatic settle_after_command();
        int idx;
        while (rec_a.size() > 0) begin
            take_record(idx);
        end
        take_record(idx);
    endtask

    task automatic send_command(input spwm_pkg::spwm_op_e op, input int freq_word);
        int waited;
        @(posedge clk);
        #5;
        cmd_op = op;
        cmd_freq = freq_word;
        cmd_req = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!cmd_ack && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        assert (cmd_ack) else report_failure($sformatf(
            "%s: cmd_ack did not rise within 20 cycles of cmd_req", test_name));
        repeat (3) @(posedge clk);
        #5;
        cmd_req = 1'b0;
        waited = 0;
        @(negedge clk);
        while (cmd_ack && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        assert (!cmd_ack) else report_failure($sformatf(
            "%s: cmd_ack did not fall within 20 cycles after cmd_req fell", test_name));
    endtask

    task automatic check_rotation(input int dir, input int steps_wanted);
        int idx;
        int prev;
        int delta;
        int step_delta;
        int steps;
        step_delta = (dir > 0) ? 1 : spwm_pkg::table_len - 1;
        steps = 0;
        take_record(prev);
        assert (prev >= 0) else report_failure($sformatf(
            "error %s: expected running pulses, actual all phases off", test_name));
        while (steps < steps_wanted) begin
            take_record(idx);
            assert (idx >= 0) else report_failure($sformatf(
                "error %s: expected running pulses, actual all phases off", test_name));
            delta = (idx - prev + spwm_pkg::table_len) % spwm_pkg::table_len;
            assert (delta == 0 || delta == step_delta) else report_failure($sformatf(
                "error %s: expected index %0d or %0d, actual %0d", test_name, prev,
                (prev + step_delta) % spwm_pkg::table_len, idx));
            if (delta != 0) begin
                steps++;
            end
            prev = idx;
        end
    endtask

    initial begin
        int idx;
        int mag;
        int held;
        int tries;
        rst = 1'b1;
        cmd_req = 1'b0;
        cmd_op = spwm_pkg::op_set_freq;
        cmd_freq = '0;
        rng_state = 82;
        last_idx = -1;
        test_name = "reset";
        repeat (10) @(posedge clk);
        #5;
        rst = 1'b0;

        test_name = "idle";
        repeat (4) begin
            take_record(idx);
            assert (idx == -1) else report_failure($sformatf(
                "error idle: expected index -1, actual %0d", idx));
            assert (!cmd_ack) else report_failure("idle: cmd_ack high with no command sent");
        end

        test_name = "forward";
        next_magnitude(mag);
        send_command(spwm_pkg::op_set_freq, mag);
        settle_after_command();
        check_rotation(1, spwm_pkg::table_len);

        test_name = "reverse";
        next_magnitude(mag);
        send_command(spwm_pkg::op_set_freq, -mag);
        settle_after_command();
        check_rotation(-1, spwm_pkg::table_len);

        test_name = "stop";
        send_command(spwm_pkg::op_stop, 0);
        settle_after_command();
        held = last_idx;
        repeat (4) begin
            take_record(idx);
            assert (idx == -1) else report_failure($sformatf(
                "error stop: expected index -1, actual %0d", idx));
        end

        // held index is the last seen one, or one step further in reverse.
        test_name = "resume";
        next_magnitude(mag);
        send_command(spwm_pkg::op_set_freq, mag);
        while (rec_a.size() > 0) begin
            take_record(idx);
        end
        tries = 0;
        take_record(idx);
        while (idx < 0 && tries < 3) begin
            take_record(idx);
            tries++;
        end
        assert (idx == held || idx == (held + spwm_pkg::table_len - 1) % spwm_pkg::table_len)
            else report_failure($sformatf("error resume: expected index %0d or %0d, actual %0d",
                held, (held + spwm_pkg::table_len - 1) % spwm_pkg::table_len, idx));
        check_rotation(1, 3);

        $display("TEST OK");
        $finish;
    end

endmodule

//--- list.f
rtl/spwm_pkg.sv
rtl/spwm_cmd_port.sv
rtl/sine_phase_stepper.sv
rtl/pwm_carrier.sv
rtl/spwm_top.sv
verification/spwm_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --assert --top-module spwm_tb -f list.f -o spwm_sim > build.log 2>&1 \
    && ./obj_dir/spwm_sim > sim.log 2>&1 \
    || echo "TEST FAILED" >> sim.log
if grep -q "TEST FAILED" sim.log; then
    echo "simulation failed, see sim.log and build.log"
    exit 1
fi
echo "simulation passed"
exit 0
